// File: Makefile
TOP := rv_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module rv_core -f build.f
	verilator --lint-only -Wall --timing --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f build.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

// File: build.f
logic/rv_pkg.sv
+incdir+dv
logic/ctrl_if.sv
logic/inst_decoder.sv
logic/alu.sv
logic/reg_file.sv
logic/pc_unit.sv
logic/rv_core.sv
dv/rv_core_tb.sv

// File: dv/rv_core_checks.svh
`ifndef RV_CORE_CHECKS_SVH
`define RV_CORE_CHECKS_SVH

int pass_count = 0;
int fail_count = 0;
bit case_failed; // Cleared at the start of each case

// Stored data, link values and addresses
task automatic compare_xlen(string tc, string sig, xlen_t got, xlen_t exp);
	if (got !== exp) begin
		$display("[ERROR] %0t %s: %s = %h, expected %h", $time, tc, sig, got, exp);
		case_failed = 1'b1;
	end
endtask

// Taken or not taken, strobe levels
task automatic compare_flag(string tc, string sig, logic got, logic exp);
	if (got !== exp) begin
		$display("[ERROR] %0t %s: %s = %b, expected %b", $time, tc, sig, got, exp);
		case_failed = 1'b1;
	end
endtask

task automatic report_timeout(string tc, string what);
	$display("%s: the core never reached the %s before the cycle limit", tc, what);
	case_failed = 1'b1;
endtask

task automatic finish_case(string tc);
	if (case_failed) begin
		fail_count++;
		$display("%s: failed", tc);
	end else begin
		pass_count++;
		$display("%s: passed", tc);
	end
endtask

`endif

// File: dv/rv_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

	localparam int          RESET_CYCLES = 16;
	localparam int          RUN_LIMIT    = 200;
	localparam xlen_t       OUT_ADDR     = 64'h800;       // Final store of every program
	localparam logic [31:0] SELF_LOOP    = 32'h0000_006f; // JAL x0, 0

	typedef enum {K_ALU, K_IMM, K_BRANCH, K_JUMP, K_UPPER, K_MEM, K_RESET} kind_e;
	typedef enum {
		OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA,
		OP_ADDI, OP_LDSD, OP_BEQ, OP_BNE, OP_BLT, OP_JAL, OP_JALR, OP_LUI, OP_AUIPC
	} op_e;

	logic        clk;
	logic        rst_n;
	xlen_t       pc;
	logic [31:0] inst;
	xlen_t       dmem_addr;
	xlen_t       dmem_wdata;
	logic        dmem_write;
	logic        dmem_read;
	xlen_t       dmem_rdata;

	logic [31:0] imem [0:63];
	xlen_t       dmem [0:511];

	// Case table
	string  name_q[$];
	kind_e  kind_q[$];
	op_e    op_q[$];
	xlen_t  a_q[$];
	xlen_t  b_q[$];
	int     imm_q[$];
	integer seed = 32'h0298_bc00;

	`include "rv_core_checks.svh"

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	rv_core i_rv_core (
		.clk        (clk),
		.rst_n      (rst_n),
		.pc         (pc),
		.inst       (inst),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_write (dmem_write),
		.dmem_read  (dmem_read),
		.dmem_rdata (dmem_rdata)
	);

	// Both memories answer in the same cycle
	assign inst       = imem[pc[7:2]];
	assign dmem_rdata = dmem[dmem_addr[11:3]];

	always @(posedge clk) begin
		if (dmem_write) begin
			dmem[dmem_addr[11:3]] <= dmem_wdata;
		end
	end

	function automatic logic [31:0] enc_r(logic [31:0] f, rd, rs1, rs2);
		return {f[9:3], rs2[4:0], rs1[4:0], f[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_addi(logic [31:0] rd, rs1, imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
	endfunction

	function automatic logic [31:0] enc_ld(logic [31:0] rd, rs1, imm);
		return {imm[11:0], rs1[4:0], 3'b011, rd[4:0], 7'b0000011};
	endfunction

	function automatic logic [31:0] enc_sd(logic [31:0] rs2, rs1, imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(logic [31:0] f3, rs1, rs2, imm);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_jal(logic [31:0] rd, imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	function automatic logic [31:0] enc_jalr(logic [31:0] rd, rs1, imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b1100111};
	endfunction

	function automatic logic [31:0] enc_u(logic [31:0] opc, rd, imm);
		return {imm[19:0], rd[4:0], opc[6:0]};
	endfunction

	// {funct7, funct3} of the R-type operations
	function automatic logic [31:0] r_funct(op_e op);
		case (op)
			OP_SUB:  return {22'd0, 7'h20, 3'b000};
			OP_SLL:  return {22'd0, 7'h00, 3'b001};
			OP_SLT:  return {22'd0, 7'h00, 3'b010};
			OP_SLTU: return {22'd0, 7'h00, 3'b011};
			OP_XOR:  return {22'd0, 7'h00, 3'b100};
			OP_SRL:  return {22'd0, 7'h00, 3'b101};
			OP_SRA:  return {22'd0, 7'h20, 3'b101};
			OP_OR:   return {22'd0, 7'h00, 3'b110};
			OP_AND:  return {22'd0, 7'h00, 3'b111};
			default: return 32'd0;
		endcase
	endfunction

	function automatic xlen_t ref_result(op_e op, xlen_t a, xlen_t b, logic [31:0] imm);
		xlen_t upper;
		upper = {{32{imm[19]}}, imm[19:0], 12'h000};
		case (op)
			OP_ADD:   return a + b;
			OP_SUB:   return a - b;
			OP_AND:   return a & b;
			OP_OR:    return a | b;
			OP_XOR:   return a ^ b;
			OP_SLT:   return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
			OP_SLTU:  return (a < b) ? 64'd1 : 64'd0;
			OP_SLL:   return a << b[5:0];
			OP_SRL:   return a >> b[5:0];
			OP_SRA:   return $signed(a) >>> b[5:0];
			OP_ADDI:  return a + {{52{imm[11]}}, imm[11:0]};
			OP_LUI:   return upper;
			OP_AUIPC: return 64'd4 + upper; // AUIPC sits at 4
			default:  return a;             // Load and store round trip
		endcase
	endfunction

	function automatic logic ref_taken(op_e op, xlen_t a, xlen_t b);
		case (op)
			OP_BEQ:  return a == b;
			OP_BNE:  return a != b;
			default: return $signed(a) < $signed(b);
		endcase
	endfunction

	// JAL sits at 8 and JALR uses x6 = 8
	function automatic xlen_t jump_target(op_e op, logic [31:0] imm);
		if (op == OP_JAL) begin
			return 64'd8 + {{43{imm[20]}}, imm[20:0]};
		end
		return (64'd8 + {{52{imm[11]}}, imm[11:0]}) & ~64'd1;
	endfunction

	function automatic xlen_t rand64();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic xlen_t fill_word(int idx);
		return 64'hc0de_0000_0000_0000 | (xlen_t'(idx) * 64'd8);
	endfunction

	task automatic add_case(string n, kind_e k, op_e o, xlen_t a, xlen_t b, int imm);
		name_q.push_back(n);
		kind_q.push_back(k);
		op_q.push_back(o);
		a_q.push_back(a);
		b_q.push_back(b);
		imm_q.push_back(imm);
	endtask

	task automatic build_table();
		xlen_t neg5;
		neg5 = 64'hffff_ffff_ffff_fffb;
		add_case("add_rand", K_ALU, OP_ADD, rand64(), rand64(), 0);
		add_case("sub_rand", K_ALU, OP_SUB, rand64(), rand64(), 0);
		add_case("and_rand", K_ALU, OP_AND, rand64(), rand64(), 0);
		add_case("or_rand", K_ALU, OP_OR, rand64(), rand64(), 0);
		add_case("xor_rand", K_ALU, OP_XOR, rand64(), rand64(), 0);
		add_case("slt_neg_pos", K_ALU, OP_SLT, neg5, 64'd3, 0);
		add_case("slt_pos_neg", K_ALU, OP_SLT, 64'd3, neg5, 0);
		add_case("sltu_big_small", K_ALU, OP_SLTU, neg5, 64'd3, 0);
		add_case("sltu_small_big", K_ALU, OP_SLTU, 64'd3, neg5, 0);
		add_case("sll_63", K_ALU, OP_SLL, rand64(), 64'd63, 0);
		add_case("sll_64", K_ALU, OP_SLL, rand64(), 64'd64, 0); // Amount wraps to 0
		add_case("srl_63", K_ALU, OP_SRL, 64'h8000_0000_0000_0000, 64'd63, 0);
		add_case("sra_63", K_ALU, OP_SRA, 64'h8000_0000_0000_0000, 64'd63, 0);
		add_case("sra_127", K_ALU, OP_SRA, rand64() | 64'h8000_0000_0000_0000, 64'd127, 0);
		add_case("addi_neg", K_IMM, OP_ADDI, rand64(), 64'd0, -1);
		add_case("addi_max", K_IMM, OP_ADDI, rand64(), 64'd0, 2047);
		add_case("ld_sd_round_trip", K_MEM, OP_LDSD, rand64(), 64'd0, 5);
		add_case("beq_equal", K_BRANCH, OP_BEQ, 64'h1234, 64'h1234, 0);
		add_case("beq_unequal", K_BRANCH, OP_BEQ, 64'd1, 64'd2, 0);
		add_case("bne_equal", K_BRANCH, OP_BNE, 64'd7, 64'd7, 0);
		add_case("bne_unequal", K_BRANCH, OP_BNE, 64'd7, 64'd8, 0);
		add_case("blt_smaller", K_BRANCH, OP_BLT, 64'd3, 64'd9, 0);
		add_case("blt_larger", K_BRANCH, OP_BLT, 64'd9, 64'd3, 0);
		add_case("blt_equal", K_BRANCH, OP_BLT, 64'd5, 64'd5, 0);
		add_case("blt_signed", K_BRANCH, OP_BLT, neg5, 64'd2, 0);
		add_case("jal_far", K_JUMP, OP_JAL, 64'd0, 64'd0, 12);
		add_case("jal_near", K_JUMP, OP_JAL, 64'd0, 64'd0, 4);
		add_case("jalr_even", K_JUMP, OP_JALR, 64'd0, 64'd0, 12);
		add_case("jalr_odd", K_JUMP, OP_JALR, 64'd0, 64'd0, 13);
		add_case("jalr_near", K_JUMP, OP_JALR, 64'd0, 64'd0, 4);
		add_case("lui_neg", K_UPPER, OP_LUI, 64'd0, 64'd0, 32'h80000);
		add_case("lui_pos", K_UPPER, OP_LUI, 64'd0, 64'd0, 32'h12345);
		add_case("auipc_neg", K_UPPER, OP_AUIPC, 64'd0, 64'd0, 32'hfffff);
		add_case("reset_mid_program", K_RESET, OP_ADD, rand64(), rand64(), 0);
	endtask

	// x5 = 0x400 so that offset 1024 reaches OUT_ADDR and 1032 the side slot
	task automatic load_program(kind_e kind, op_e op, logic [31:0] imm);
		for (int k = 0; k < 64; k++) begin
			imem[k] <= SELF_LOOP;
		end
		imem[0] <= enc_addi(5, 0, 1024);
		if (kind == K_UPPER) begin
			imem[1] <= enc_u((op == OP_LUI) ? 32'h37 : 32'h17, 3, imm);
			imem[2] <= enc_sd(3, 5, 1024);
		end else if (kind == K_JUMP) begin
			imem[1] <= enc_addi(6, 0, 8);
			imem[2] <= (op == OP_JAL) ? enc_jal(1, imm) : enc_jalr(1, 6, imm);
			imem[3] <= enc_addi(3, 0, 1); // Fall-through marker
			imem[4] <= enc_jal(0, 8);
			imem[5] <= enc_addi(3, 0, 2); // Target marker at 20
			imem[6] <= enc_sd(1, 5, 1032);
			imem[7] <= enc_sd(3, 5, 1024);
		end else begin
			imem[1] <= enc_ld(1, 0, 0);
			imem[2] <= enc_ld(2, 0, 8);
			case (kind)
				K_IMM: imem[3] <= enc_addi(3, 1, imm);
				K_BRANCH: begin
					imem[3] <= enc_b((op == OP_BEQ) ? 0 : (op == OP_BNE) ? 1 : 4, 1, 2, 12);
					imem[4] <= enc_addi(3, 0, 1);
					imem[5] <= enc_jal(0, 8);
					imem[6] <= enc_addi(3, 0, 2);
				end
				K_MEM: begin
					imem[3] <= enc_sd(1, 0, 16);
					imem[4] <= enc_ld(3, 0, 16);
					imem[5] <= enc_addi(0, 1, imm); // Must not change x0
					imem[6] <= enc_sd(0, 5, 1032);
				end
				default: imem[3] <= enc_r(r_funct(op), 3, 1, 2);
			endcase
			imem[(kind == K_BRANCH || kind == K_MEM) ? 7 : 4] <= enc_sd(3, 5, 1024);
		end
	endtask

	task automatic load_memories(int i);
		for (int k = 0; k < 512; k++) begin
			dmem[k] <= fill_word(k);
		end
		dmem[0] <= a_q[i];
		dmem[1] <= b_q[i];
		load_program(kind_q[i], op_q[i], imm_q[i]);
	endtask

	task automatic enter_reset(string tc);
		@(posedge clk);
		rst_n <= 1'b0;
		@(negedge clk);
		compare_flag(tc, "dmem_write", dmem_write, 1'b0); // Gated at once
	endtask

	task automatic hold_reset(string tc);
		repeat (RESET_CYCLES - 1) begin
			@(posedge clk);
			@(negedge clk);
			compare_xlen(tc, "pc", pc, RESET_PC);
		end
		@(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic wait_pc(string tc, xlen_t target, output bit ok);
		int n;
		ok = 1'b0;
		n = 0;
		while (!ok && n < RUN_LIMIT) begin
			@(negedge clk);
			ok = (pc == target);
			n++;
		end
		if (!ok) begin
			report_timeout(tc, "mid-program pc");
		end
	endtask

	task automatic wait_store(string tc, output xlen_t data, output bit ok);
		int n;
		ok = 1'b0;
		n = 0;
		data = '0;
		while (!ok && n < RUN_LIMIT) begin
			@(negedge clk);
			// Only LD reads data memory
			compare_flag(tc, "dmem_read", dmem_read, inst[6:0] == 7'b0000011);
			if (dmem_write && dmem_addr == OUT_ADDR) begin
				data = dmem_wdata;
				ok = 1'b1;
			end
			n++;
		end
		if (!ok) begin
			report_timeout(tc, "final store to 0x800");
		end
	endtask

	task automatic check_result(int i, xlen_t got);
		string tc;
		xlen_t exp;
		tc = name_q[i];
		exp = ref_result(op_q[i], a_q[i], b_q[i], imm_q[i]);
		case (kind_q[i])
			K_BRANCH: begin
				compare_flag(tc, "marker valid", got == 64'd1 || got == 64'd2, 1'b1);
				compare_flag(tc, "branch taken", got == 64'd2, ref_taken(op_q[i], a_q[i], b_q[i]));
			end
			K_JUMP: begin
				compare_xlen(tc, "link dmem[0x808]", dmem[257], 64'd12); // Jump sits at 8
				exp = (jump_target(op_q[i], imm_q[i]) == 64'd20) ? 64'd2 : 64'd1;
				compare_xlen(tc, "marker", got, exp);
			end
			K_MEM: begin
				compare_xlen(tc, "dmem_wdata", got, exp);
				compare_xlen(tc, "x0 dmem[0x808]", dmem[257], 64'd0);
			end
			default: compare_xlen(tc, "dmem_wdata", got, exp);
		endcase
	endtask

	task automatic run_case(int i);
		xlen_t got;
		bit    ok;
		case_failed = 1'b0;
		enter_reset(name_q[i]);
		load_memories(i);
		hold_reset(name_q[i]);
		if (kind_q[i] == K_RESET) begin
			wait_pc(name_q[i], 64'd12, ok); // OP presented, store still ahead
			enter_reset(name_q[i]);
			hold_reset(name_q[i]);
			@(negedge clk);
			compare_xlen(name_q[i], "pc after restart", pc, RESET_PC);
		end
		wait_store(name_q[i], got, ok);
		if (ok) begin
			check_result(i, got);
		end
		finish_case(name_q[i]);
	endtask

	initial begin
		rst_n <= 1'b0;
		for (int k = 0; k < 64; k++) begin
			imem[k] <= SELF_LOOP;
		end
		for (int k = 0; k < 512; k++) begin
			dmem[k] <= fill_word(k);
		end
		build_table();
		for (int i = 0; i < name_q.size(); i++) begin
			run_case(i);
		end
		$display("%0d cases passed, %0d cases failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu import rv_pkg::*; (
	input  alu_op_e op,
	input  xlen_t   a,
	input  xlen_t   b,
	output xlen_t   y,
	output logic    zero,
	output logic    less
);

	logic [5:0] shamt;
	logic       less_u;

	assign shamt  = b[5:0]; // RV64 shifts use six bits
	assign less   = $signed(a) < $signed(b); // Shared by SLT and BLT
	assign less_u = a < b;

	always_comb begin
		case (op)
			ALU_ADD:
				y = a + b;
			ALU_SUB:
				y = a - b;
			ALU_AND:
				y = a & b;
			ALU_OR:
				y = a | b;
			ALU_XOR:
				y = a ^ b;
			ALU_SLT:
				y = {63'b0, less};
			ALU_SLTU:
				y = {63'b0, less_u};
			ALU_SLL:
				y = a << shamt;
			ALU_SRL:
				y = a >> shamt;
			ALU_SRA:
				y = $signed(a) >>> shamt; // Keeps the sign bit
			ALU_PASS_B:
				y = b; // LUI
			default:
				y = '0;
		endcase
	end

	assign zero = (y == '0);

endmodule

`default_nettype wire

// File: logic/ctrl_if.sv
`timescale 1ns/100ps
`default_nettype none

// Decoded control bundle, decoder to datapath and PC unit
interface ctrl_if import rv_pkg::*; (
	input wire logic clk,
	input wire logic rst_n
);

	alu_op_e    alu_op;
	a_sel_e     a_sel;
	b_sel_e     b_sel;
	wb_sel_e    wb_sel;
	pc_sel_e    pc_sel;
	logic       reg_write;
	logic       mem_write;
	logic       mem_read;
	logic [2:0] br_funct3; // Branch condition code

	modport dec (
		input  clk, rst_n,
		output alu_op, a_sel, b_sel, wb_sel, pc_sel,
		output reg_write, mem_write, mem_read, br_funct3
	);

	modport dp (
		input alu_op, a_sel, b_sel, wb_sel, reg_write, mem_write, mem_read
	);

	modport pc (input pc_sel, br_funct3);

endinterface

`default_nettype wire

// File: logic/inst_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decoder import rv_pkg::*; (
	input  inst_u     inst,
	output reg_addr_t rs1,
	output reg_addr_t rs2,
	output reg_addr_t rd,
	output xlen_t     imm,
	ctrl_if.dec       ctrl
);

	logic known_op; // Low for an opcode outside the subset
	logic alt;      // Bit 30 selects SUB and SRA

	// Register fields sit at the same place in every format
	assign rs1 = inst.r.rs1;
	assign rs2 = inst.r.rs2;
	assign rd  = inst.r.rd;
	assign alt = inst.r.funct7[5];

	// Immediate, one format view per opcode
	always_comb begin
		case (inst.r.opcode)
			OPC_OP_IMM, OPC_LOAD, OPC_JALR:
				imm = {{52{inst.i.imm[11]}}, inst.i.imm};
			OPC_STORE:
				imm = {{52{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
			OPC_BRANCH:
				imm = {{51{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
					inst.b.imm10_5, inst.b.imm4_1, 1'b0};
			OPC_LUI, OPC_AUIPC:
				imm = {{32{inst.u.imm[19]}}, inst.u.imm, 12'h000};
			OPC_JAL:
				imm = {{43{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
					inst.j.imm11, inst.j.imm10_1, 1'b0};
			default:
				imm = '0; // R-type has none
		endcase
	end

	always_comb begin
		ctrl.alu_op    = ALU_ADD;
		ctrl.a_sel     = A_RS1;
		ctrl.b_sel     = B_RS2;
		ctrl.wb_sel    = WB_ALU;
		ctrl.pc_sel    = PC_PLUS4;
		ctrl.reg_write = 1'b0;
		ctrl.mem_write = 1'b0;
		ctrl.mem_read  = 1'b0;
		ctrl.br_funct3 = inst.b.funct3;
		known_op       = 1'b1;

		case (inst.r.opcode)
			OPC_OP: begin
				ctrl.reg_write = 1'b1;
				case (inst.r.funct3)
					F3_ADD_SUB: ctrl.alu_op = alt ? ALU_SUB : ALU_ADD;
					F3_SLL:     ctrl.alu_op = ALU_SLL;
					F3_SLT:     ctrl.alu_op = ALU_SLT;
					F3_SLTU:    ctrl.alu_op = ALU_SLTU;
					F3_XOR:     ctrl.alu_op = ALU_XOR;
					F3_SRL_SRA: ctrl.alu_op = alt ? ALU_SRA : ALU_SRL;
					F3_OR:      ctrl.alu_op = ALU_OR;
					F3_AND:     ctrl.alu_op = ALU_AND;
				endcase
			end
			OPC_OP_IMM: begin // ADDI only
				ctrl.b_sel     = B_IMM;
				ctrl.reg_write = 1'b1;
			end
			OPC_LOAD: begin
				ctrl.b_sel     = B_IMM;
				ctrl.wb_sel    = WB_MEM;
				ctrl.reg_write = 1'b1;
				ctrl.mem_read  = 1'b1;
			end
			OPC_STORE: begin
				ctrl.b_sel     = B_IMM;
				ctrl.mem_write = 1'b1;
			end
			OPC_BRANCH: begin
				ctrl.alu_op = ALU_SUB; // Zero flag gives equality
				ctrl.pc_sel = PC_BRANCH;
			end
			OPC_JAL: begin
				ctrl.a_sel     = A_PC;
				ctrl.b_sel     = B_IMM;
				ctrl.wb_sel    = WB_PC4;
				ctrl.pc_sel    = PC_JAL;
				ctrl.reg_write = 1'b1;
			end
			OPC_JALR: begin
				ctrl.b_sel     = B_IMM;
				ctrl.wb_sel    = WB_PC4;
				ctrl.pc_sel    = PC_JALR;
				ctrl.reg_write = 1'b1;
			end
			OPC_LUI: begin
				ctrl.alu_op    = ALU_PASS_B;
				ctrl.b_sel     = B_IMM;
				ctrl.reg_write = 1'b1;
			end
			OPC_AUIPC: begin
				ctrl.a_sel     = A_PC;
				ctrl.b_sel     = B_IMM;
				ctrl.reg_write = 1'b1;
			end
			default: known_op = 1'b0;
		endcase
	end

	// Fetch must only ever deliver opcodes of the subset once running
	a_known_opcode: assert property (
		@(posedge ctrl.clk) disable iff (!ctrl.rst_n) known_op
	) else $error("unsupported opcode %07b", inst.r.opcode);

endmodule

`default_nettype wire

// File: logic/pc_unit.sv
`timescale 1ns/100ps
`default_nettype none

module pc_unit import rv_pkg::*; (
	input  wire logic clk,
	input  wire logic rst_n,
	ctrl_if.pc        ctrl,
	input  xlen_t     imm,
	input  xlen_t     alu_y,
	input  wire logic zero,
	input  wire logic less,
	output xlen_t     pc,
	output xlen_t     pc_plus4
);

	logic  taken;
	xlen_t next_pc;

	assign pc_plus4 = pc + INST_BYTES;

	// Condition from the ALU flags of rs1 - rs2
	always_comb begin
		case (ctrl.br_funct3)
			F3_BEQ:  taken = zero;
			F3_BNE:  taken = !zero;
			F3_BLT:  taken = less;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		case (ctrl.pc_sel)
			PC_BRANCH: next_pc = taken ? pc + imm : pc_plus4;
			PC_JAL:    next_pc = alu_y; // pc + imm from the ALU
			PC_JALR:   next_pc = {alu_y[63:1], 1'b0};
			default:   next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= RESET_PC;
		end else begin
			pc <= next_pc;
		end
	end

	// Alignment must hold for every target the core ever takes
	a_pc_aligned: assert property (
		@(posedge clk) disable iff (!rst_n) ##1 pc[1:0] == 2'b00
	) else $error("misaligned pc %h", pc);

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file import rv_pkg::*; (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic write,
	input  reg_addr_t rs1,
	input  reg_addr_t rs2,
	input  reg_addr_t rd,
	input  xlen_t     wdata,
	output xlen_t     rdata1,
	output xlen_t     rdata2
);

	xlen_t regs [31:1]; // x0 has no storage

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	// Combinational reads
	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

	// A register written on one edge reads back its new value on the next
	a_write_read: assert property (
		@(posedge clk) disable iff (!rst_n)
		(write && rd != '0) |=> (rs1 != $past(rd) || rdata1 == $past(wdata))
	) else $error("register read back stale data");

endmodule

`default_nettype wire

// File: logic/rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core import rv_pkg::*; (
	input  wire logic        clk,
	input  wire logic        rst_n,
	output xlen_t            pc,
	input  wire logic [31:0] inst,
	output xlen_t            dmem_addr,
	output xlen_t            dmem_wdata,
	output logic             dmem_write,
	output logic             dmem_read,
	input  xlen_t            dmem_rdata
);

	inst_u     inst_w;
	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	reg_addr_t rd_addr;
	xlen_t     imm;
	xlen_t     rdata1;
	xlen_t     rdata2;
	xlen_t     alu_a;
	xlen_t     alu_b;
	xlen_t     alu_y;
	logic      alu_zero;
	logic      alu_less;
	xlen_t     pc_plus4;
	xlen_t     wb_data;
	logic      reg_we;

	ctrl_if i_ctrl (
		.clk   (clk),
		.rst_n (rst_n)
	);

	assign inst_w = inst; // Same word, viewed by format

	inst_decoder i_inst_decoder (
		.inst (inst_w),
		.rs1  (rs1_addr),
		.rs2  (rs2_addr),
		.rd   (rd_addr),
		.imm  (imm),
		.ctrl (i_ctrl.dec)
	);

	reg_file i_reg_file (
		.clk    (clk),
		.rst_n  (rst_n),
		.write  (reg_we),
		.rs1    (rs1_addr),
		.rs2    (rs2_addr),
		.rd     (rd_addr),
		.wdata  (wb_data),
		.rdata1 (rdata1),
		.rdata2 (rdata2)
	);

	// Operand muxes
	assign alu_a = (i_ctrl.a_sel == A_PC) ? pc : rdata1;
	assign alu_b = (i_ctrl.b_sel == B_IMM) ? imm : rdata2;

	alu i_alu (
		.op   (i_ctrl.alu_op),
		.a    (alu_a),
		.b    (alu_b),
		.y    (alu_y),
		.zero (alu_zero),
		.less (alu_less)
	);

	pc_unit i_pc_unit (
		.clk      (clk),
		.rst_n    (rst_n),
		.ctrl     (i_ctrl.pc),
		.imm      (imm),
		.alu_y    (alu_y),
		.zero     (alu_zero),
		.less     (alu_less),
		.pc       (pc),
		.pc_plus4 (pc_plus4)
	);

	// Write-back source
	always_comb begin
		case (i_ctrl.wb_sel)
			WB_MEM:  wb_data = dmem_rdata;
			WB_PC4:  wb_data = pc_plus4; // Link address
			default: wb_data = alu_y;
		endcase
	end

	// Strobes stay quiet while in reset
	assign reg_we     = i_ctrl.reg_write & rst_n;
	assign dmem_write = i_ctrl.mem_write & rst_n;
	assign dmem_read  = i_ctrl.mem_read & rst_n;

	assign dmem_addr  = alu_y; // rs1 + imm
	assign dmem_wdata = rdata2;

endmodule

`default_nettype wire

// File: logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

	typedef logic [63:0] xlen_t;
	typedef logic [4:0]  reg_addr_t;

	localparam xlen_t RESET_PC   = 64'h0; // First fetch after reset
	localparam xlen_t INST_BYTES = 64'd4;

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111
	} opcode_e;

	// funct3 of OP
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct3 of BRANCH
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_BLT = 3'b100;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
		ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;
	typedef enum logic {A_RS1, A_PC} a_sel_e;
	typedef enum logic {B_RS2, B_IMM} b_sel_e;
	typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JAL, PC_JALR} pc_sel_e;

	// Instruction formats, fields at their architectural bit positions
	typedef struct packed {
		logic [6:0] funct7; // [31:25]
		reg_addr_t  rs2;    // [24:20]
		reg_addr_t  rs1;    // [19:15]
		logic [2:0] funct3; // [14:12]
		reg_addr_t  rd;     // [11:7]
		opcode_e    opcode; // [6:0]
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		reg_addr_t   rs1;
		logic [2:0]  funct3;
		reg_addr_t   rd;
		opcode_e     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi; // imm[11:5]
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo; // imm[4:0]
		opcode_e    opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		opcode_e    opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm; // imm[31:12]
		reg_addr_t   rd;
		opcode_e     opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		reg_addr_t  rd;
		opcode_e    opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} inst_u;

endpackage

`default_nettype wire
